// File: Makefile
# Verilator build and run of the exec_core testbench

VERILATOR ?= verilator
TOP ?= tb_exec_core
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
MUL_LATENCY ?= 3
VERILATOR_FLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables:"
	@echo "  VERILATOR VERILATOR_FLAGS TOP FILELIST BUILD_DIR MUL_LATENCY"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) \
		-GMUL_LATENCY=$(MUL_LATENCY) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim.f
+incdir+include
source/exec_pkg.sv
source/alu_unit.sv
source/mul_unit.sv
source/rob.sv
source/issue_ctrl.sv
source/exec_core.sv
testbench/tb_exec_core.sv

// File: source/alu_unit.sv
`timescale 1ns/100ps

module alu_unit import exec_pkg::*; (
	input logic clk,
	input logic start,
	input op_t op,
	input word_t a,
	input word_t b,
	output word_t result
);
	// result holds until the next start
	always_ff @(posedge clk) begin
		if (start) begin
			case (op)
				OP_ADD: begin
					result <= a + b;
				end
				OP_SUB: begin
					result <= a - b;
				end
				OP_AND: begin
					result <= a & b;
				end
				OP_XOR: begin
					result <= a ^ b;
				end
				default: begin
					result <= '0;
				end
			endcase
		end
	end
endmodule

// File: source/exec_core.sv
`timescale 1ns/100ps

module exec_core import exec_pkg::*; #(
	parameter int MUL_LATENCY = 3
) (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input issue_req_t issue_req,
	output logic issue_ready,
	output logic commit_valid,
	output commit_t commit,
	input logic commit_ready
);
	logic full;
	logic alloc;
	logic alu_start;
	cdb_slot_t wb_slot;
	word_t alu_result;
	word_t mul_result;

	// the mul pipeline samples every cycle, its slot picks the result
	issue_ctrl #(.MUL_LATENCY(MUL_LATENCY)) issue_ctrl (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_req,
		.issue_ready,
		.full,
		.alloc,
		.alu_start,
		.mul_start(),
		.wb_slot
	);

	alu_unit alu_unit (
		.clk,
		.start(alu_start),
		.op(issue_req.op),
		.a(issue_req.a),
		.b(issue_req.b),
		.result(alu_result)
	);

	mul_unit #(.MUL_LATENCY(MUL_LATENCY)) mul_unit (
		.clk,
		.a(issue_req.a),
		.b(issue_req.b),
		.result(mul_result)
	);

	rob rob (
		.clk,
		.rst_n,
		.alloc,
		.wb_slot,
		.alu_result,
		.mul_result,
		.full,
		.commit_valid,
		.commit,
		.commit_ready
	);
endmodule

// File: source/exec_pkg.sv
package exec_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;

	localparam int ROB_TAG_W = 3;
	localparam int ROB_DEPTH = 2 ** ROB_TAG_W;

	// tags follow issue order and wrap with the ROB
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;

	////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_XOR,
		OP_MUL
	} op_t;

	typedef enum logic {
		UNIT_ALU,
		UNIT_MUL
	} unit_t;

	////////////////////////////////////////////////////////////
	// channel payloads
	////////////////////////////////////////////////////////////

	typedef struct packed {
		op_t op;
		word_t a;
		word_t b;
	} issue_req_t;

	// one reservation of the result bus
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		unit_t unit;
	} cdb_slot_t;

	typedef struct packed {
		rob_tag_t tag;
		word_t data;
	} commit_t;

endpackage

// File: source/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl import exec_pkg::*; #(
	parameter int MUL_LATENCY = 3
) (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input issue_req_t issue_req,
	output logic issue_ready,
	input logic full,
	output logic alloc,
	output logic alu_start,
	output logic mul_start,
	output cdb_slot_t wb_slot
);
	// rsv[0] owns the bus now, rsv[i] owns it i cycles ahead
	cdb_slot_t rsv[MUL_LATENCY];
	rob_tag_t next_tag;
	logic is_mul;
	logic accept;

	////////////////////////////////////////////////////////////
	// issue decision
	////////////////////////////////////////////////////////////

	assign is_mul = issue_req.op == OP_MUL;

	// deepest unit always wins, the ALU needs the next slot free
	assign issue_ready = !full && (is_mul || !rsv[1].valid);
	assign accept = issue_valid && issue_ready;

	assign alloc = accept;
	assign alu_start = accept && !is_mul;
	assign mul_start = accept && is_mul;

	// tag counter, tracks the rob tail
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			next_tag <= '0;
		end else if (accept) begin
			next_tag <= next_tag + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// result bus reservations
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MUL_LATENCY; i++) begin
				rsv[i] <= '0;
			end
		end else begin
			for (int i = 1; i < MUL_LATENCY - 1; i++) begin
				rsv[i] <= rsv[i+1];
			end
			// top slot is always empty before the shift
			if (mul_start) begin
				rsv[MUL_LATENCY-1] <= cdb_slot_t'{
					valid: 1'b1,
					tag: next_tag,
					unit: UNIT_MUL
				};
			end else begin
				rsv[MUL_LATENCY-1] <= '0;
			end
			if (alu_start) begin
				rsv[0] <= cdb_slot_t'{
					valid: 1'b1,
					tag: next_tag,
					unit: UNIT_ALU
				};
			end else begin
				rsv[0] <= rsv[1];
			end
		end
	end

	assign wb_slot = rsv[0];
endmodule

// File: source/mul_unit.sv
`timescale 1ns/100ps

module mul_unit import exec_pkg::*; #(
	parameter int MUL_LATENCY = 3
) (
	input logic clk,
	input word_t a,
	input word_t b,
	output word_t result
);
	word_t stage[MUL_LATENCY];
	word_t product;

	// low half only
	assign product = a * b;

	always_ff @(posedge clk) begin
		stage[0] <= product;
		for (int i = 1; i < MUL_LATENCY; i++) begin
			stage[i] <= stage[i-1];
		end
	end

	// one product per cycle, MUL_LATENCY in flight
	assign result = stage[MUL_LATENCY-1];
endmodule

// File: source/rob.sv
`timescale 1ns/100ps

module rob import exec_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic alloc,
	input cdb_slot_t wb_slot,
	input word_t alu_result,
	input word_t mul_result,
	output logic full,
	output logic commit_valid,
	output commit_t commit,
	input logic commit_ready
);
	typedef logic [ROB_TAG_W:0] rob_cnt_t;

	logic entry_done[ROB_DEPTH];
	word_t entry_data[ROB_DEPTH];
	rob_tag_t head;
	rob_tag_t tail;
	rob_cnt_t count;
	logic empty;
	logic commit_fire;
	word_t wb_data;

	////////////////////////////////////////////////////////////
	// occupancy
	////////////////////////////////////////////////////////////

	assign full = count == rob_cnt_t'(ROB_DEPTH);
	assign empty = (head == tail) && !full;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (alloc) begin
				tail <= tail + 1'b1;
			end
			if (commit_fire) begin
				head <= head + 1'b1;
			end
			case ({alloc, commit_fire})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// writeback
	////////////////////////////////////////////////////////////

	assign wb_data = (wb_slot.unit == UNIT_MUL) ? mul_result : alu_result;

	// writeback never targets the head being committed
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				entry_done[i] <= 1'b0;
			end
		end else begin
			if (commit_fire) begin
				entry_done[head] <= 1'b0;
			end
			if (wb_slot.valid) begin
				entry_done[wb_slot.tag] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb_slot.valid) begin
			entry_data[wb_slot.tag] <= wb_data;
		end
	end

	////////////////////////////////////////////////////////////
	// in-order commit
	////////////////////////////////////////////////////////////

	assign commit_valid = !empty && entry_done[head];
	assign commit_fire = commit_valid && commit_ready;
	assign commit = commit_t'{
		tag: head,
		data: entry_data[head]
	};
endmodule

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// compare tasks
////////////////////////////////////////////////////////////

task automatic report_fail(input string name, input string exp_s, input string act_s);
	$display("FAIL at %0t: %s expected %s actual %s", $time, name, exp_s, act_s);
	$display("*** TEST FAILED ***");
	$fatal(1);
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
	if (act !== exp) begin
		report_fail(name, $sformatf("%h", exp), $sformatf("%h", act));
	end
endtask

task automatic check_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
	if (act !== exp) begin
		report_fail(name, $sformatf("%0d", exp), $sformatf("%0d", act));
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		report_fail(name, $sformatf("%b", exp), $sformatf("%b", act));
	end
endtask

////////////////////////////////////////////////////////////
// stimulus and reference
////////////////////////////////////////////////////////////

// fibonacci lfsr, taps 32 22 2 1, one bit per step
function automatic word_t lfsr_step(input word_t state);
	logic fb;
	fb = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], fb};
endfunction

function automatic word_t lfsr_advance(input word_t state, input int unsigned n);
	word_t s;
	s = state;
	for (int unsigned i = 0; i < n; i++) begin
		s = lfsr_step(s);
	end
	return s;
endfunction

function automatic word_t ref_result(input issue_req_t req);
	case (req.op)
		OP_ADD: return req.a + req.b;
		OP_SUB: return req.a - req.b;
		OP_AND: return req.a & req.b;
		OP_XOR: return req.a ^ req.b;
		OP_MUL: return req.a * req.b;
		default: return '0;
	endcase
endfunction

`endif

// File: testbench/tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core import exec_pkg::*; #(
	parameter int MUL_LATENCY = 3
);
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_OPS = 40;
	// singles, mul burst, bus conflict, full rob, random
	localparam int TOTAL_OPS = 5 + 3 + 4 + 9 + RANDOM_OPS;
	localparam int WATCHDOG_CYCLES = 200 * TOTAL_OPS + 500;

	localparam int RDY_LOW = 0;
	localparam int RDY_HIGH = 1;
	localparam int RDY_RANDOM = 2;

	logic clk = 1'b0;
	logic rst_n;
	logic issue_valid;
	issue_req_t issue_req;
	logic issue_ready;
	logic commit_valid;
	commit_t commit;
	logic commit_ready;

	commit_t expected_q[$];
	int unsigned issued = 0;
	int rdy_mode = RDY_HIGH;
	word_t op_lfsr;
	word_t rdy_lfsr;

	`include "tb_checks.svh"

	exec_core #(.MUL_LATENCY(MUL_LATENCY)) UUT (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_req,
		.issue_ready,
		.commit_valid,
		.commit,
		.commit_ready
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic issue_req_t make_req(input op_t op, input word_t a, input word_t b);
		issue_req_t req;
		req.op = op;
		req.a = a;
		req.b = b;
		return req;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	// called on a falling edge, returns on the falling edge after the transfer
	task automatic issue_op(input issue_req_t req, output logic ready_at_offer);
		commit_t exp;
		logic first;
		logic taken;
		exp.tag = rob_tag_t'(issued % ROB_DEPTH);
		exp.data = ref_result(req);
		first = 1'b1;
		taken = 1'b0;
		ready_at_offer = 1'b0;
		issue_valid = 1'b1;
		issue_req = req;
		while (!taken) begin
			#1;
			if (first) begin
				ready_at_offer = issue_ready;
			end
			first = 1'b0;
			if (issue_ready === 1'b1) begin
				expected_q.push_back(exp);
				issued = issued + 1;
				taken = 1'b1;
			end
			@(negedge clk);
		end
	endtask

	task automatic idle_cycles(input int n);
		issue_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic wait_drained();
		issue_valid = 1'b0;
		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// changed on a rising edge so the commit side picks it up on the next falling edge
	task automatic set_ready_mode(input int mode);
		@(posedge clk);
		rdy_mode = mode;
	endtask

	task automatic random_req(output issue_req_t req);
		logic [2:0] sel;
		op_lfsr = lfsr_advance(op_lfsr, 3);
		sel = op_lfsr[2:0];
		if (sel > 3'd4) begin
			sel = sel - 3'd5;
		end
		req.op = op_t'(sel);
		op_lfsr = lfsr_advance(op_lfsr, 32);
		req.a = op_lfsr;
		op_lfsr = lfsr_advance(op_lfsr, 32);
		req.b = op_lfsr;
	endtask

	////////////////////////////////////////////////////////////
	// commit side and scoreboard
	////////////////////////////////////////////////////////////

	task automatic check_commit();
		commit_t exp;
		if (expected_q.size() == 0) begin
			stop_with_error("commit handshake with no operation outstanding");
		end else begin
			exp = expected_q.pop_front();
			check_tag("commit.tag", exp.tag, commit.tag);
			check_word("commit.data", exp.data, commit.data);
		end
	endtask

	initial begin : commit_side
		commit_ready = 1'b0;
		rdy_lfsr = 32'd4;
		forever begin
			@(negedge clk);
			if (rdy_mode == RDY_LOW) begin
				commit_ready = 1'b0;
			end else if (rdy_mode == RDY_HIGH) begin
				commit_ready = 1'b1;
			end else begin
				rdy_lfsr = lfsr_step(rdy_lfsr);
				commit_ready = rdy_lfsr[0];
			end
			#1;
			if (rst_n && commit_valid === 1'b1 && commit_ready) begin
				check_commit();
			end
		end
	end

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_single_ops();
		logic rdy;
		#1;
		check_bit("commit_valid", 1'b0, commit_valid);
		check_bit("issue_ready", 1'b1, issue_ready);
		@(negedge clk);
		for (int i = 0; i < 5; i++) begin
			issue_op(make_req(op_t'(i), 32'h9abc_def0 ^ word_t'(i), 32'h0000_7013), rdy);
			wait_drained();
		end
	endtask

	// the ADD result lands before the multiply but commits after it
	task automatic test_mul_then_alu();
		logic rdy;
		issue_op(make_req(OP_MUL, 32'h0001_0003, 32'h0000_0111), rdy);
		issue_op(make_req(OP_ADD, 32'h0000_00aa, 32'h0000_0055), rdy);
		issue_op(make_req(OP_XOR, 32'hffff_0000, 32'h0f0f_0f0f), rdy);
		wait_drained();
	endtask

	task automatic test_bus_conflict();
		logic rdy;
		issue_op(make_req(OP_MUL, 32'h0000_0007, 32'h0000_0009), rdy);
		idle_cycles(MUL_LATENCY - 2);
		issue_valid = 1'b1;
		issue_req = make_req(OP_SUB, 32'h0000_0100, 32'h0000_0001);
		#1;
		check_bit("issue_ready", 1'b0, issue_ready);
		@(negedge clk);
		issue_op(make_req(OP_SUB, 32'h0000_0100, 32'h0000_0001), rdy);
		check_bit("issue_ready", 1'b1, rdy);
		wait_drained();
		issue_op(make_req(OP_MUL, 32'h0000_000b, 32'h0000_000d), rdy);
		idle_cycles(MUL_LATENCY - 2);
		issue_op(make_req(OP_MUL, 32'h8000_0001, 32'h0000_0003), rdy);
		check_bit("issue_ready", 1'b1, rdy);
		wait_drained();
	endtask

	task automatic test_rob_full();
		logic rdy;
		set_ready_mode(RDY_LOW);
		@(negedge clk);
		for (int i = 0; i < ROB_DEPTH; i++) begin
			issue_op(make_req(op_t'(i % 5), 32'h0000_0100 + word_t'(i),
				32'h0000_0003 + word_t'(i)), rdy);
		end
		// ninth op waits on full
		issue_valid = 1'b1;
		issue_req = make_req(OP_ADD, 32'h1111_1111, 32'h2222_2222);
		repeat (MUL_LATENCY + 2) begin
			#1;
			check_bit("issue_ready", 1'b0, issue_ready);
			@(negedge clk);
		end
		#1;
		check_bit("commit_valid", 1'b1, commit_valid);
		set_ready_mode(RDY_HIGH);
		@(negedge clk);
		issue_op(make_req(OP_ADD, 32'h1111_1111, 32'h2222_2222), rdy);
		wait_drained();
	endtask

	task automatic test_random_ops();
		issue_req_t req;
		logic rdy;
		set_ready_mode(RDY_RANDOM);
		@(negedge clk);
		for (int i = 0; i < RANDOM_OPS; i++) begin
			random_req(req);
			issue_op(req, rdy);
			op_lfsr = lfsr_advance(op_lfsr, 2);
			if (op_lfsr[1:0] == 2'b00) begin
				idle_cycles(1);
			end
		end
		wait_drained();
		set_ready_mode(RDY_HIGH);
	endtask

	////////////////////////////////////////////////////////////
	// run
	////////////////////////////////////////////////////////////

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$fatal(1);
	end

	initial begin : main_sequence
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_req = '0;
		op_lfsr = 32'd4;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		test_single_ops();
		test_mul_then_alu();
		test_bus_conflict();
		test_rob_full();
		test_random_ops();
		// rob empty and no reservations left
		@(negedge clk);
		#1;
		check_bit("commit_valid", 1'b0, commit_valid);
		check_bit("issue_ready", 1'b1, issue_ready);
		$display("*** TEST PASSED ***");
		$finish;
	end
endmodule
